//--- flist.f
dma_pcie_pkg.sv
dma_regs_pkg.sv
gray_pointer_sync.sv
completion_reorder_fifo.sv
read_request_engine.sv
axil_dma_regs.sv
dma_read_channel.sv
tb_host_model.sv
tb_dma_read_channel.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dma_read_channel
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FLIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_dma_read_channel.sv
`timescale 1ns/1ps

module tb_dma_read_channel;

   localparam logic [4:0]  CHANNEL    = 5'd3;
   localparam logic [63:0] BASE       = 64'h0000_0001_2340_0000;
   localparam int          BLOCKS     = 24;
   localparam int          WAIT_LIMIT = 20000;

   logic                        clock = 1'b0;
   logic                        fifo_clock = 1'b0;
   logic                        reset;
   dma_regs_pkg::axil_req_t     s_axil_req;
   dma_regs_pkg::axil_rsp_t     s_axil_rsp;
   dma_pcie_pkg::read_request_t read_request;
   logic                        read_request_valid;
   logic                        read_request_ready;
   dma_pcie_pkg::completion_t   completion;
   logic                        fifo_read;
   logic [63:0]                 fifo_read_data;
   logic                        fifo_read_valid;

   logic       reader_enable;
   logic [1:0] read_history;
   int         accepted_count;
   int         stream_words;
   logic [31:0] read_value;
   logic [1:0]  read_resp;

   always #10 clock = ~clock;
   always #7 fifo_clock = ~fifo_clock;

   dma_read_channel #(.CHANNEL(CHANNEL)) DUT
   (
      .clock              (clock),
      .reset              (reset),
      .s_axil_req         (s_axil_req),
      .s_axil_rsp         (s_axil_rsp),
      .read_request       (read_request),
      .read_request_valid (read_request_valid),
      .read_request_ready (read_request_ready),
      .completion         (completion),
      .fifo_clock         (fifo_clock),
      .fifo_read          (fifo_read),
      .fifo_read_data     (fifo_read_data),
      .fifo_read_valid    (fifo_read_valid)
   );

   tb_host_model host
   (
      .clock              (clock),
      .reset              (reset),
      .read_request       (read_request),
      .read_request_valid (read_request_valid),
      .read_request_ready (read_request_ready),
      .completion         (completion)
   );

   task automatic value_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
      $display("FAIL at %0t ns: %s expected %h actual %h", $time, name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_problem(input string what);
      $display("Problem at %0t ns: %s", $time, what);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at first error");
   endtask

   // ========================================
   // AXI4-Lite manager
   // ========================================
   task automatic axil_write(input logic [31:0] address, input logic [31:0] data);
      bit aw_done;
      bit w_done;
      int cycles;
      aw_done = 1'b0;
      w_done  = 1'b0;
      cycles  = 0;
      s_axil_req.aw_valid <= 1'b1;
      s_axil_req.aw_addr  <= address;
      s_axil_req.w_valid  <= 1'b1;
      s_axil_req.w_data   <= data;
      s_axil_req.w_strb   <= 4'hF;
      s_axil_req.b_ready  <= 1'b1;
      while (!(aw_done && w_done))
      begin
         @(posedge clock);
         if (s_axil_req.aw_valid && s_axil_rsp.aw_ready)
         begin
            aw_done = 1'b1;
            s_axil_req.aw_valid <= 1'b0;
         end
         if (s_axil_req.w_valid && s_axil_rsp.w_ready)
         begin
            w_done = 1'b1;
            s_axil_req.w_valid <= 1'b0;
         end
         cycles = cycles + 1;
         if (cycles > 100)
            report_problem("register write address or data never accepted");
      end
      cycles = 0;
      do
      begin
         @(posedge clock);
         cycles = cycles + 1;
         if (cycles > 100)
            report_problem("register write response never arrived");
      end
      while (!s_axil_rsp.b_valid);
      s_axil_req.b_ready <= 1'b0;
      assert (s_axil_rsp.b_resp == 2'b00)
         else value_mismatch("b_resp", 64'd0, 64'(s_axil_rsp.b_resp));
   endtask

   task automatic axil_read(input logic [31:0] address, output logic [31:0] data,
                            output logic [1:0] resp);
      int cycles;
      cycles = 0;
      s_axil_req.ar_valid <= 1'b1;
      s_axil_req.ar_addr  <= address;
      s_axil_req.r_ready  <= 1'b1;
      do
      begin
         @(posedge clock);
         cycles = cycles + 1;
         if (cycles > 100)
            report_problem("register read address never accepted");
      end
      while (!(s_axil_req.ar_valid && s_axil_rsp.ar_ready));
      s_axil_req.ar_valid <= 1'b0;
      cycles = 0;
      do
      begin
         @(posedge clock);
         cycles = cycles + 1;
         if (cycles > 100)
            report_problem("register read data never arrived");
      end
      while (!s_axil_rsp.r_valid);
      s_axil_req.r_ready <= 1'b0;
      data = s_axil_rsp.r_data;
      resp = s_axil_rsp.r_resp;
   endtask

   // ========================================
   // Request and stream checks
   // ========================================
   always @(posedge clock)
   begin
      logic [63:0] expected_address;
      int          outstanding;
      if (!reset && read_request_valid && read_request_ready)
      begin
         expected_address = BASE + 64'(accepted_count) * 64'd512;
         assert (read_request.address == expected_address)
            else value_mismatch("read_request.address", expected_address, read_request.address);
         assert (read_request.tag.channel == CHANNEL)
            else value_mismatch("read_request.tag.channel", 64'(CHANNEL),
                                64'(read_request.tag.channel));
         assert (read_request.tag.slot == 3'(accepted_count % 8))
            else value_mismatch("read_request.tag.slot", 64'(accepted_count % 8),
                                64'(read_request.tag.slot));
         assert (read_request.length == 10'd128)
            else value_mismatch("read_request.length", 64'd128, 64'(read_request.length));
         outstanding = accepted_count + 1 - stream_words / 64;   // Requested minus drained
         assert (outstanding <= 6)
            else value_mismatch("outstanding blocks", 64'd6, 64'(outstanding));
         accepted_count <= accepted_count + 1;
      end
   end

   always @(posedge fifo_clock)
      fifo_read <= reader_enable && ($urandom_range(3) != 0);

   always @(posedge fifo_clock)
   begin
      logic [63:0] address;
      address = BASE + 64'(stream_words) * 64'd8;
      read_history <= {read_history[0], fifo_read};
      if (fifo_read_valid)
      begin
         assert (read_history[1])
            else report_problem("fifo_read_valid without a fifo_read two cycles before");
         assert (stream_words < BLOCKS * 64)
            else report_problem("more stream words than requested");
         assert (fifo_read_data == {address[31:0], ~address[31:0]})
            else value_mismatch("fifo_read_data", {address[31:0], ~address[31:0]},
                                fifo_read_data);
         stream_words <= stream_words + 1;
      end
   end

   // ========================================
   // Test sequence
   // ========================================
   initial
   begin
      int cycles;
      void'($urandom(32'hb186_b7e4));
      reset          = 1'b1;
      s_axil_req     = '0;
      fifo_read      = 1'b0;
      reader_enable  = 1'b0;
      read_history   = '0;
      accepted_count = 0;
      stream_words   = 0;
      repeat (10) @(posedge clock);
      reset <= 1'b0;
      repeat (5) @(posedge clock);
      reader_enable <= 1'b1;   // Reads into an empty FIFO must be ignored

      axil_write(dma_regs_pkg::reg_base_lo, BASE[31:0]);
      axil_write(dma_regs_pkg::reg_base_hi, BASE[63:32]);
      axil_write(dma_regs_pkg::reg_count, 32'(BLOCKS));
      axil_read(dma_regs_pkg::reg_base_lo, read_value, read_resp);
      assert (read_value == BASE[31:0])
         else value_mismatch("base_lo", 64'(BASE[31:0]), 64'(read_value));
      axil_read(dma_regs_pkg::reg_base_hi, read_value, read_resp);
      assert (read_value == BASE[63:32])
         else value_mismatch("base_hi", 64'(BASE[63:32]), 64'(read_value));
      axil_read(dma_regs_pkg::reg_count, read_value, read_resp);
      assert (read_value == 32'(BLOCKS))
         else value_mismatch("count", 64'(BLOCKS), 64'(read_value));
      axil_read(32'h40, read_value, read_resp);
      assert (read_resp == 2'b10)
         else value_mismatch("r_resp", 64'd2, 64'(read_resp));
      assert (read_value == 32'd0)
         else value_mismatch("r_data", 64'd0, 64'(read_value));
      assert (stream_words == 0)
         else report_problem("stream words appeared before the run started");

      axil_write(dma_regs_pkg::reg_control, 32'd1);

      cycles = 0;
      while (stream_words < 128)
      begin
         @(posedge clock);
         cycles = cycles + 1;
         if (cycles > WAIT_LIMIT)
            report_problem("first two blocks never reached the stream");
      end
      reader_enable <= 1'b0;

      // Engine must fill the window and then stall
      cycles = 0;
      while (accepted_count - stream_words / 64 != 6)
      begin
         @(posedge clock);
         cycles = cycles + 1;
         if (cycles > WAIT_LIMIT)
            report_problem("outstanding window never filled while the reader paused");
      end
      repeat (300) @(posedge clock);
      reader_enable <= 1'b1;

      cycles = 0;
      while (stream_words < BLOCKS * 64)
      begin
         @(posedge clock);
         cycles = cycles + 1;
         if (cycles > WAIT_LIMIT)
            report_problem("stream never completed after the reader resumed");
      end

      axil_read(dma_regs_pkg::reg_status, read_value, read_resp);
      assert (read_value[1] == 1'b1)
         else value_mismatch("status.done", 64'd1, 64'(read_value[1]));
      assert (read_value[0] == 1'b0)
         else value_mismatch("status.busy", 64'd0, 64'(read_value[0]));
      assert (read_value[31:16] == 16'(BLOCKS))
         else value_mismatch("status.requested", 64'(BLOCKS), 64'(read_value[31:16]));
      assert (accepted_count == BLOCKS)
         else value_mismatch("accepted requests", 64'(BLOCKS), 64'(accepted_count));
      repeat (40) @(posedge fifo_clock);

      $display("NO ERRORS");
      $finish;
   end

endmodule

//--- tb_host_model.sv
`timescale 1ns/1ps

module tb_host_model
(
   input  logic                        clock,
   input  logic                        reset,
   input  dma_pcie_pkg::read_request_t read_request,
   input  logic                        read_request_valid,
   output logic                        read_request_ready,
   output dma_pcie_pkg::completion_t   completion
);

   localparam int QUEUE_DEPTH = 4;

   logic [63:0]        entry_address [QUEUE_DEPTH];
   dma_pcie_pkg::tag_t entry_tag     [QUEUE_DEPTH];
   logic [63:0]        entry_sent    [QUEUE_DEPTH];   // One bit per word already sent
   int                 entry_left    [QUEUE_DEPTH];
   bit                 entry_busy    [QUEUE_DEPTH];

   initial
   begin
      read_request_ready = 1'b0;
      completion         = '0;
      for (int i = 0; i < QUEUE_DEPTH; i++)
         entry_busy[i] = 1'b0;
   end

   // Random starting point gives interleaving across queued blocks
   function automatic int choose_entry();
      int start;
      start = int'($urandom_range(QUEUE_DEPTH - 1));
      for (int k = 0; k < QUEUE_DEPTH; k++)
         if (entry_busy[(start + k) % QUEUE_DEPTH])
            return (start + k) % QUEUE_DEPTH;
      return -1;
   endfunction

   function automatic int choose_word(input int entry);
      int span;
      int start;
      span  = (entry_left[entry] > 1) ? 63 : 64;   // Word 63 closes the block and goes out last
      start = int'($urandom_range(span - 1));
      for (int k = 0; k < span; k++)
         if (!entry_sent[entry][(start + k) % span])
            return (start + k) % span;
      return 63;
   endfunction

   always @(posedge clock)
   begin
      int                        pick;
      int                        word;
      int                        free;
      logic [63:0]               address;
      dma_pcie_pkg::completion_t next;
      if (reset)
      begin
         for (int i = 0; i < QUEUE_DEPTH; i++)
            entry_busy[i] = 1'b0;
         read_request_ready <= 1'b0;
         completion         <= '0;
      end
      else
      begin
         if (read_request_valid && read_request_ready)
         begin
            for (int i = 0; i < QUEUE_DEPTH; i++)
               if (!entry_busy[i])
               begin
                  entry_busy[i]    = 1'b1;
                  entry_address[i] = read_request.address;
                  entry_tag[i]     = read_request.tag;
                  entry_sent[i]    = '0;
                  entry_left[i]    = 64;
                  break;
               end
         end
         next = '0;
         if ($urandom_range(7) == 0)
         begin
            // Traffic for another channel must be ignored
            next.valid       = 1'b1;
            next.tag.channel = 5'd5;
            next.tag.slot    = 3'($urandom_range(7));
            next.index       = 6'($urandom_range(63));
            next.data        = {$urandom, $urandom};
         end
         else
         begin
            pick = choose_entry();
            if (pick >= 0)
            begin
               word    = choose_word(pick);
               address = entry_address[pick] + 64'(word) * 64'd8;
               next.valid = 1'b1;
               next.tag   = entry_tag[pick];
               next.index = 6'(word);
               next.data  = {address[31:0], ~address[31:0]};
               entry_sent[pick][word] = 1'b1;
               entry_left[pick]       = entry_left[pick] - 1;
               if (entry_left[pick] == 0)
                  entry_busy[pick] = 1'b0;
            end
         end
         completion <= next;
         free = 0;
         for (int i = 0; i < QUEUE_DEPTH; i++)
            if (!entry_busy[i])
               free = free + 1;
         read_request_ready <= (free > 0) && ($urandom_range(3) != 0);
      end
   end

endmodule

//--- dma_read_channel.sv
`timescale 1ns/1ps

module dma_read_channel
#(
   parameter logic [4:0] CHANNEL = 5'd0
)
(
   input  logic                        clock,
   input  logic                        reset,
   input  dma_regs_pkg::axil_req_t     s_axil_req,
   output dma_regs_pkg::axil_rsp_t     s_axil_rsp,
   output dma_pcie_pkg::read_request_t read_request,
   output logic                        read_request_valid,
   input  logic                        read_request_ready,
   input  dma_pcie_pkg::completion_t   completion,
   input  logic                        fifo_clock,
   input  logic                        fifo_read,
   output logic [63:0]                 fifo_read_data,
   output logic                        fifo_read_valid
);

   dma_regs_pkg::dma_control_t control;
   dma_regs_pkg::dma_status_t  status;
   logic                       slot_available;
   logic                       slot_taken;

   axil_dma_regs regs
   (
      .clock      (clock),
      .reset      (reset),
      .s_axil_req (s_axil_req),
      .s_axil_rsp (s_axil_rsp),
      .control    (control),
      .status     (status)
   );

   read_request_engine #(.CHANNEL(CHANNEL)) engine
   (
      .clock              (clock),
      .reset              (reset),
      .control            (control),
      .status             (status),
      .slot_available     (slot_available),
      .slot_taken         (slot_taken),
      .read_request       (read_request),
      .read_request_valid (read_request_valid),
      .read_request_ready (read_request_ready)
   );

   completion_reorder_fifo #(.CHANNEL(CHANNEL)) reorder
   (
      .clock           (clock),
      .reset           (reset),
      .completion      (completion),
      .slot_available  (slot_available),
      .slot_taken      (slot_taken),
      .fifo_clock      (fifo_clock),
      .fifo_read       (fifo_read),
      .fifo_read_data  (fifo_read_data),
      .fifo_read_valid (fifo_read_valid)
   );

endmodule

//--- axil_dma_regs.sv
`timescale 1ns/1ps

module axil_dma_regs
(
   input  logic                       clock,
   input  logic                       reset,
   input  dma_regs_pkg::axil_req_t    s_axil_req,
   output dma_regs_pkg::axil_rsp_t    s_axil_rsp,
   output dma_regs_pkg::dma_control_t control,
   input  dma_regs_pkg::dma_status_t  status
);

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   logic        aw_held, w_held;
   logic [31:0] aw_addr_q, w_data_q;
   logic [3:0]  w_strb_q;
   logic        aw_ready, w_ready, aw_take, w_take, do_write;
   logic [31:0] wr_addr, wr_data;
   logic [3:0]  wr_strb;
   logic        b_valid, r_valid;
   logic [1:0]  b_resp, r_resp;
   logic [31:0] r_data;
   logic [31:0] base_lo, base_hi, count_merged, read_data;
   logic [15:0] block_count;
   logic        start, read_hit;

   function automatic logic [31:0] apply_strobe(input logic [31:0] old_value,
                                                input logic [31:0] new_value,
                                                input logic [3:0]  strobe);
      logic [31:0] merged;
      merged = old_value;
      for (int i = 0; i < 4; i++)
         if (strobe[i])
            merged[8*i +: 8] = new_value[8*i +: 8];
      return merged;
   endfunction

   // ========================================
   // Write path
   // ========================================
   assign aw_ready = !aw_held && !b_valid;
   assign w_ready  = !w_held && !b_valid;
   assign aw_take  = s_axil_req.aw_valid && aw_ready;
   assign w_take   = s_axil_req.w_valid && w_ready;
   assign do_write = (aw_held || aw_take) && (w_held || w_take);   // Both halves present

   assign wr_addr      = aw_held ? aw_addr_q : s_axil_req.aw_addr;
   assign wr_data      = w_held ? w_data_q : s_axil_req.w_data;
   assign wr_strb      = w_held ? w_strb_q : s_axil_req.w_strb;
   assign count_merged = apply_strobe({16'd0, block_count}, wr_data, wr_strb);

   always_ff @(posedge clock)
   begin
      if (aw_take)
         aw_addr_q <= s_axil_req.aw_addr;
      if (w_take)
      begin
         w_data_q <= s_axil_req.w_data;
         w_strb_q <= s_axil_req.w_strb;
      end
   end

   // ========================================
   // Read path
   // ========================================
   always_comb
   begin
      read_hit  = 1'b1;
      read_data = '0;
      case (s_axil_req.ar_addr)
         dma_regs_pkg::reg_base_lo: read_data = base_lo;
         dma_regs_pkg::reg_base_hi: read_data = base_hi;
         dma_regs_pkg::reg_count:   read_data = {16'd0, block_count};
         dma_regs_pkg::reg_control: read_data = '0;   // Start is a pulse
         dma_regs_pkg::reg_status:
            read_data = {status.requested, 14'd0, status.done, status.busy};
         default:                   read_hit = 1'b0;
      endcase
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         aw_held     <= 1'b0;
         w_held      <= 1'b0;
         b_valid     <= 1'b0;
         b_resp      <= RESP_OKAY;
         r_valid     <= 1'b0;
         r_resp      <= RESP_OKAY;
         start       <= 1'b0;
         base_lo     <= '0;
         base_hi     <= '0;
         block_count <= '0;
      end
      else
      begin
         start   <= 1'b0;
         aw_held <= (aw_held || aw_take) && !do_write;
         w_held  <= (w_held || w_take) && !do_write;
         if (do_write)
         begin
            b_valid <= 1'b1;
            b_resp  <= RESP_OKAY;
            case (wr_addr)
               dma_regs_pkg::reg_base_lo: base_lo <= apply_strobe(base_lo, wr_data, wr_strb);
               dma_regs_pkg::reg_base_hi: base_hi <= apply_strobe(base_hi, wr_data, wr_strb);
               dma_regs_pkg::reg_count:   block_count <= count_merged[15:0];
               dma_regs_pkg::reg_control: start <= wr_data[0] && wr_strb[0];
               dma_regs_pkg::reg_status:  ;   // Read only
               default:                   b_resp <= RESP_SLVERR;
            endcase
         end
         else if (b_valid && s_axil_req.b_ready)
            b_valid <= 1'b0;
         if (s_axil_req.ar_valid && !r_valid)
         begin
            r_valid <= 1'b1;
            r_resp  <= read_hit ? RESP_OKAY : RESP_SLVERR;
         end
         else if (r_valid && s_axil_req.r_ready)
            r_valid <= 1'b0;
      end
   end

   always_ff @(posedge clock)
   begin
      if (s_axil_req.ar_valid && !r_valid)
         r_data <= read_data;
   end

   always_comb
   begin
      s_axil_rsp.aw_ready = aw_ready;
      s_axil_rsp.w_ready  = w_ready;
      s_axil_rsp.b_valid  = b_valid;
      s_axil_rsp.b_resp   = b_resp;
      s_axil_rsp.ar_ready = !r_valid;   // One read in flight
      s_axil_rsp.r_valid  = r_valid;
      s_axil_rsp.r_data   = r_data;
      s_axil_rsp.r_resp   = r_resp;
   end

   assign control.base  = {base_hi, base_lo};
   assign control.count = block_count;
   assign control.start = start;

endmodule

//--- read_request_engine.sv
`timescale 1ns/1ps

module read_request_engine
#(
   parameter logic [4:0] CHANNEL = 5'd0
)
(
   input  logic                        clock,
   input  logic                        reset,
   input  dma_regs_pkg::dma_control_t  control,
   output dma_regs_pkg::dma_status_t   status,
   input  logic                        slot_available,
   output logic                        slot_taken,
   output dma_pcie_pkg::read_request_t read_request,
   output logic                        read_request_valid,
   input  logic                        read_request_ready
);

   localparam int SLOT_BITS  = $clog2(dma_pcie_pkg::block_slots);
   localparam int BLOCK_BITS = $clog2(dma_pcie_pkg::block_bytes);

   logic [63:0] base_address;
   logic [15:0] block_count;
   logic [15:0] requested;
   logic        busy;
   logic        done;
   logic        transfer;
   logic        last_transfer;

   assign transfer      = read_request_valid && read_request_ready;
   assign last_transfer = transfer && (requested + 16'd1 == block_count);
   assign slot_taken    = transfer;

   // Payload follows the transfer count, so it holds while valid waits
   assign read_request.address     = base_address + (64'(requested) << BLOCK_BITS);
   assign read_request.tag.channel = CHANNEL;
   assign read_request.tag.slot    = requested[SLOT_BITS-1:0];
   assign read_request.length      = 10'(dma_pcie_pkg::block_bytes / 4);

   assign status.busy      = busy;
   assign status.done      = done;
   assign status.requested = requested;

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         busy               <= 1'b0;
         done               <= 1'b0;
         requested          <= '0;
         read_request_valid <= 1'b0;
      end
      else if (control.start)
      begin
         busy               <= control.count != 16'd0;
         done               <= control.count == 16'd0;   // Empty run finishes at once
         requested          <= '0;
         read_request_valid <= (control.count != 16'd0) && slot_available;
      end
      else if (busy)
      begin
         if (last_transfer)
         begin
            busy               <= 1'b0;
            done               <= 1'b1;
            read_request_valid <= 1'b0;
         end
         else if (transfer || !read_request_valid)
            read_request_valid <= slot_available;
         if (transfer)
            requested <= requested + 16'd1;
      end
   end

   always_ff @(posedge clock)
   begin
      if (control.start)
      begin
         base_address <= control.base;
         block_count  <= control.count;
      end
   end

endmodule

//--- completion_reorder_fifo.sv
`timescale 1ns/1ps

module completion_reorder_fifo
#(
   parameter logic [4:0] CHANNEL = 5'd0
)
(
   input  logic                      clock,
   input  logic                      reset,
   input  dma_pcie_pkg::completion_t completion,
   output logic                      slot_available,
   input  logic                      slot_taken,
   input  logic                      fifo_clock,
   input  logic                      fifo_read,
   output logic [63:0]               fifo_read_data,
   output logic                      fifo_read_valid
);

   localparam int SLOTS      = dma_pcie_pkg::block_slots;
   localparam int WORDS      = dma_pcie_pkg::block_words;
   localparam int SLOT_BITS  = $clog2(SLOTS);
   localparam int INDEX_BITS = $clog2(WORDS);
   localparam int ADDR_BITS  = SLOT_BITS + INDEX_BITS;

   logic [63:0]          ram [0:SLOTS*WORDS-1];
   logic [SLOTS-1:0]     block_filled;
   logic [SLOT_BITS-1:0] p_write;
   logic [SLOT_BITS-1:0] p_request;
   logic [SLOT_BITS-1:0] p_read;        // Drained blocks, seen in clock
   logic [SLOT_BITS-1:0] outstanding;
   logic                 write;
   logic                 write_last;
   logic [ADDR_BITS-1:0] write_address;

   // ========================================
   // Fill side, clock domain
   // ========================================
   assign write         = completion.valid && (completion.tag.channel == CHANNEL);
   assign write_address = {completion.tag.slot, completion.index};
   assign write_last    = write && (completion.index == INDEX_BITS'(WORDS - 1));

   // Counts the slot being taken this cycle so the engine never overshoots
   assign outstanding    = p_request + SLOT_BITS'(slot_taken) - p_read;
   assign slot_available = outstanding < SLOT_BITS'(dma_pcie_pkg::max_outstanding);

   always_ff @(posedge clock)
   begin
      if (write)
         ram[write_address] <= completion.data;
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         block_filled <= '0;
         p_write      <= '0;
         p_request    <= '0;
      end
      else
      begin
         for (int i = 0; i < SLOTS; i++)
            block_filled[i] <= (write_last && (completion.tag.slot == SLOT_BITS'(i)))
                               || (block_filled[i] && (p_write != SLOT_BITS'(i)));
         p_write   <= p_write + SLOT_BITS'(block_filled[p_write]);   // In-order release
         p_request <= p_request + SLOT_BITS'(slot_taken);
      end
   end

   // ========================================
   // Drain side, fifo_clock domain
   // ========================================
   logic                 reset_meta;
   logic                 reset_fclk;
   logic [ADDR_BITS-1:0] p_read_word;
   logic [SLOT_BITS-1:0] p_write_fclk;
   logic                 read_accept;
   logic                 read_valid_q;
   logic [63:0]          ram_oreg;

   always_ff @(posedge fifo_clock)
   begin
      reset_meta <= reset;
      reset_fclk <= reset_meta;
   end

   gray_pointer_sync #(.WIDTH(SLOT_BITS)) sync_write
   (
      .clock_in  (clock),
      .in        (p_write),
      .clock_out (fifo_clock),
      .out       (p_write_fclk),
      .reset_out (reset_fclk)
   );

   gray_pointer_sync #(.WIDTH(SLOT_BITS)) sync_read
   (
      .clock_in  (fifo_clock),
      .in        (p_read_word[ADDR_BITS-1 -: SLOT_BITS]),
      .clock_out (clock),
      .out       (p_read),
      .reset_out (reset)
   );

   assign read_accept = fifo_read && (p_read_word[ADDR_BITS-1 -: SLOT_BITS] != p_write_fclk);

   always_ff @(posedge fifo_clock)
   begin
      ram_oreg       <= ram[p_read_word];
      fifo_read_data <= ram_oreg;
   end

   always_ff @(posedge fifo_clock)
   begin
      if (reset_fclk)
      begin
         p_read_word     <= '0;
         read_valid_q    <= 1'b0;
         fifo_read_valid <= 1'b0;
      end
      else
      begin
         p_read_word     <= p_read_word + ADDR_BITS'(read_accept);
         read_valid_q    <= read_accept;
         fifo_read_valid <= read_valid_q;   // Matches the two data registers
      end
   end

endmodule

//--- gray_pointer_sync.sv
`timescale 1ns/1ps

module gray_pointer_sync
#(
   parameter int WIDTH = 3
)
(
   input  logic             clock_in,
   input  logic [WIDTH-1:0] in,
   input  logic             clock_out,
   output logic [WIDTH-1:0] out,
   input  logic             reset_out
);

   logic [WIDTH-1:0] gray_in;
   logic [WIDTH-1:0] gray_meta;
   logic [WIDTH-1:0] gray_sync;

   // Only one bit moves per increment
   always_ff @(posedge clock_in)
   begin
      gray_in <= in ^ (in >> 1);
   end

   always_ff @(posedge clock_out)
   begin
      if (reset_out)
      begin
         gray_meta <= '0;
         gray_sync <= '0;
      end
      else
      begin
         gray_meta <= gray_in;
         gray_sync <= gray_meta;
      end
   end

   // Each binary bit is the XOR of all Gray bits at or above it
   always_comb
   begin
      for (int i = 0; i < WIDTH; i++)
         out[i] = ^(gray_sync >> i);
   end

endmodule

//--- dma_regs_pkg.sv
package dma_regs_pkg;

   // ========================================
   // AXI4-Lite channels
   // ========================================
   typedef struct packed {
      logic        aw_valid;
      logic [31:0] aw_addr;
      logic        w_valid;
      logic [31:0] w_data;
      logic [3:0]  w_strb;
      logic        b_ready;
      logic        ar_valid;
      logic [31:0] ar_addr;
      logic        r_ready;
   } axil_req_t;

   typedef struct packed {
      logic        aw_ready;
      logic        w_ready;
      logic        b_valid;
      logic [1:0]  b_resp;
      logic        ar_ready;
      logic        r_valid;
      logic [31:0] r_data;
      logic [1:0]  r_resp;
   } axil_rsp_t;

   // ========================================
   // Register map
   // ========================================
   localparam logic [31:0] reg_base_lo = 32'h00;
   localparam logic [31:0] reg_base_hi = 32'h04;
   localparam logic [31:0] reg_count   = 32'h08;
   localparam logic [31:0] reg_control = 32'h0C;
   localparam logic [31:0] reg_status  = 32'h10;

   typedef struct packed {
      logic [63:0] base;
      logic [15:0] count;    // Blocks per run
      logic        start;    // One-cycle pulse
   } dma_control_t;

   typedef struct packed {
      logic        busy;
      logic        done;
      logic [15:0] requested;
   } dma_status_t;

endpackage

//--- dma_pcie_pkg.sv
package dma_pcie_pkg;

   // ========================================
   // Reorder buffer geometry
   // ========================================
   localparam int block_slots     = 8;
   localparam int block_words     = 64;   // 64-bit words per block
   localparam int block_bytes     = 512;
   localparam int max_outstanding = 6;    // Requested but not yet drained

   // Upper field routes to the channel, lower field picks the RAM slot
   typedef struct packed {
      logic [4:0] channel;
      logic [2:0] slot;
   } tag_t;

   // ========================================
   // Transaction payloads
   // ========================================
   typedef struct packed {
      logic [63:0] address;   // Host byte address
      tag_t        tag;
      logic [9:0]  length;    // Dwords, always a full block
   } read_request_t;

   typedef struct packed {
      logic        valid;
      tag_t        tag;
      logic [5:0]  index;     // Word within the block
      logic [63:0] data;
   } completion_t;

endpackage
